//--- src.f
+incdir+rtl
rtl/lsp_pkg.sv
rtl/frame_pkg.sv
rtl/lsp_lane_if.sv
rtl/lsp_loader.sv
rtl/lsp_scalar_quantizer.sv
rtl/frame_packer.sv
rtl/codec2_frame_encoder.sv
tb/clock_gen.sv
tb/codec2_frame_encoder_sva.sv
tb/tb_codec2_frame_encoder.sv

//--- Bender.yml
package:
  name: codec2_frame_encoder

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsp_pkg.sv
      - rtl/frame_pkg.sv
      - rtl/lsp_lane_if.sv
      - rtl/lsp_loader.sv
      - rtl/lsp_scalar_quantizer.sv
      - rtl/frame_packer.sv
      - rtl/codec2_frame_encoder.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/clock_gen.sv
      - tb/codec2_frame_encoder_sva.sv
      - tb/tb_codec2_frame_encoder.sv

//--- tb/tb_codec2_frame_encoder.sv
`include "codec2_params.svh"

module tb_codec2_frame_encoder import lsp_pkg::*, frame_pkg::*;
();

	// 22 frames of about 23 cycles plus reset
	localparam int max_cycles = 1000;

	logic clk;
	logic rst;
	logic start;
	lsp_vec_t lsp_in;
	logic voiced_first;
	logic voiced_second;
	woe_index_t woe_index;
	frame_bits_t encoded_bits;
	logic done_frame;
	string test_name = "reset";
	int cycles = 0;
	lsp_vec_t vec;

	clock_gen u_clk (.clk(clk));

	codec2_frame_encoder dut (.*);

	// one frame, optionally disturbed by a start while in flight
	task automatic run_frame(input lsp_vec_t v, input logic vf, input logic vs,
		input woe_index_t w, input bit stray);
		@(posedge clk);
		start <= 1'b1;
		lsp_in <= v;
		voiced_first <= vf;
		voiced_second <= vs;
		woe_index <= w;
		@(posedge clk);
		start <= 1'b0;
		if (stray)
		begin
			repeat (3) @(posedge clk);
			start <= 1'b1;
			lsp_in <= ~v;
			voiced_first <= ~vf;
			voiced_second <= ~vs;
			woe_index <= ~w;
			@(posedge clk);
			start <= 1'b0;
		end
		do
			@(negedge clk);
		while (done_frame);
		do
			@(negedge clk);
		while (!done_frame);
	endtask

	task automatic random_frame(input bit stray);
		lsp_vec_t v;
		for (int l = 0; l < `LSP_COUNT; l++)
			v[l] = lsp_t'($urandom_range(40000, 0));
		run_frame(v, 1'($urandom), 1'($urandom), woe_index_t'($urandom), stray);
	endtask

	initial
	begin
		void'($urandom(32'hd479_3c18));
		rst <= 1'b0;
		start <= 1'b0;
		lsp_in <= '0;
		voiced_first <= 1'b0;
		voiced_second <= 1'b0;
		woe_index <= '0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		test_name = "random";
		repeat (12)
		begin
			repeat ($urandom_range(3, 0)) @(posedge clk);
			random_frame(1'b0);
		end
		test_name = "below_range";
		run_frame('0, 1'b1, 1'b0, 8'h5a, 1'b0);
		test_name = "above_range";
		run_frame('1, 1'b0, 1'b1, 8'hff, 1'b0);
		// exactly between entries 1 and 2 of every row
		test_name = "midway";
		for (int l = 0; l < `LSP_COUNT; l++)
			vec[l] = lsp_t'((int'(lsp_codebook[l][1]) + int'(lsp_codebook[l][2])) / 2);
		run_frame(vec, 1'b1, 1'b1, 8'h81, 1'b0);
		test_name = "start_in_flight";
		repeat (3) random_frame(1'b1);
		test_name = "back_to_back";
		repeat (4) random_frame(1'b0);
		repeat (2) @(negedge clk);
		if (dut.u_sva.fail_count != 0)
		begin
			$display("SOME TESTS FAILED");
			$fatal(1, "assertion failures in %s", test_name);
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// first failure and timeout
	// ------------------------------------------------------------
	always @(negedge clk)
	begin
		if (dut.u_sva.fail_count != 0)
		begin
			if (dut.u_sva.fail_id == 2)
				$display("mismatch in %s: expected %h, actual %h", test_name,
					dut.u_sva.bad_expected, dut.u_sva.bad_actual);
			else
				$display("failure in %s: handshake check %0d did not hold", test_name,
					dut.u_sva.fail_id);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first failure");
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout in %s: run did not finish in %0d cycles", test_name, max_cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

endmodule

//--- tb/codec2_frame_encoder_sva.sv
`include "codec2_params.svh"

module codec2_frame_encoder_sva import lsp_pkg::*, frame_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input lsp_vec_t lsp_in,
	input logic voiced_first,
	input logic voiced_second,
	input woe_index_t woe_index,
	input frame_bits_t encoded_bits,
	input logic done_frame
);

	int fail_count = 0;
	int fail_id = 0;
	frame_bits_t bad_expected;
	frame_bits_t bad_actual;
	frame_bits_t exp_bits;
	logic in_flight;
	logic started;
	logic done_q;
	logic busy;
	logic accept;

	// nearest entry per LSP, lower index on ties, then Gray coded fields
	function automatic frame_bits_t reference_frame(lsp_vec_t v, logic vf, logic vs,
		woe_index_t w);
		frame_bits_t word;
		int size;
		int best;
		int best_d;
		int d;
		word = frame_bits_t'({vf, vs, w ^ (w >> 1)});
		for (int l = 0; l < `LSP_COUNT; l++)
		begin
			size = (l < 7) ? 16 : ((l < 9) ? 8 : 4);
			best = 0;
			best_d = 1 << 20;
			for (int e = 0; e < size; e++)
			begin
				d = int'(v[l]) - int'(lsp_codebook[l][e]);
				if (d < 0)
					d = -d;
				if (d < best_d)
				begin
					best = e;
					best_d = d;
				end
			end
			word = (word << $clog2(size)) | frame_bits_t'(best ^ (best >> 1));
		end
		return word << 2;
	endfunction

	// ------------------------------------------------------------
	// frame tracking, busy ends in the cycle done_frame rises
	// ------------------------------------------------------------
	assign busy = in_flight && !(done_frame && !done_q);
	assign accept = start && !busy;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			in_flight <= 1'b0;
			started <= 1'b0;
			done_q <= 1'b0;
			exp_bits <= '0;
		end
		else
		begin
			in_flight <= accept || busy;
			done_q <= done_frame;
			if (accept)
			begin
				started <= 1'b1;
				exp_bits <= reference_frame(lsp_in, voiced_first, voiced_second, woe_index);
			end
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (!rst)
		!started |-> !done_frame && encoded_bits == '0)
	else
	begin
		$error("output not idle before the first frame");
		fail_id = 1;
		fail_count++;
	end

	// skips the one cycle where a new start has not yet cleared done_frame
	a_value: assert property (@(posedge clk) disable iff (!rst)
		done_frame && (!in_flight || !done_q) |-> encoded_bits == exp_bits)
	else
	begin
		$error("frame word differs from reference");
		bad_expected = $sampled(exp_bits);
		bad_actual = $sampled(encoded_bits);
		fail_id = 2;
		fail_count++;
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst)
		accept |-> ##[1:40] (done_frame && !done_q))
	else
	begin
		$error("no done_frame within 40 cycles of start");
		fail_id = 3;
		fail_count++;
	end

	a_clear: assert property (@(posedge clk) disable iff (!rst)
		accept && done_frame |-> ##2 !done_frame)
	else
	begin
		$error("done_frame not cleared by a new start");
		fail_id = 4;
		fail_count++;
	end

endmodule

bind codec2_frame_encoder codec2_frame_encoder_sva u_sva (.*);

//--- tb/clock_gen.sv
module clock_gen
(
	output logic clk
);

	// period of 100
	initial
		clk = 1'b0;

	always
		#50 clk = ~clk;

endmodule

//--- rtl/codec2_frame_encoder.sv
`include "codec2_params.svh"

module codec2_frame_encoder import lsp_pkg::*, frame_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  lsp_vec_t lsp_in,
	input  logic voiced_first,
	input  logic voiced_second,
	input  woe_index_t woe_index,
	output frame_bits_t encoded_bits,
	output logic done_frame
);

	logic voiced_first_q;
	logic voiced_second_q;
	woe_index_t woe_index_q;
	logic frame_complete;

	lsp_lane_if lanes [`LSP_COUNT] ();

	lsp_loader u_loader
	(
		.clk (clk),
		.rst (rst),
		.start (start),
		.lsp_in (lsp_in),
		.voiced_first (voiced_first),
		.voiced_second (voiced_second),
		.woe_index (woe_index),
		.frame_complete (frame_complete),
		.lanes (lanes),
		.voiced_first_q (voiced_first_q),
		.voiced_second_q (voiced_second_q),
		.woe_index_q (woe_index_q)
	);

	// one search lane per LSP
	for (genvar g = 0; g < `LSP_COUNT; g++)
	begin : g_lane
		lsp_scalar_quantizer #(.lane_num(g)) u_quant
		(
			.clk (clk),
			.rst (rst),
			.lane (lanes[g])
		);
	end

	frame_packer u_packer
	(
		.clk (clk),
		.rst (rst),
		.lanes (lanes),
		.voiced_first_q (voiced_first_q),
		.voiced_second_q (voiced_second_q),
		.woe_index_q (woe_index_q),
		.encoded_bits (encoded_bits),
		.done_frame (done_frame),
		.frame_complete (frame_complete)
	);

endmodule

//--- rtl/frame_packer.sv
`include "codec2_params.svh"

module frame_packer import lsp_pkg::*, frame_pkg::*;
(
	input  logic clk,
	input  logic rst,
	lsp_lane_if.packer lanes [`LSP_COUNT],
	input  logic voiced_first_q,
	input  logic voiced_second_q,
	input  woe_index_t woe_index_q,
	output frame_bits_t encoded_bits,
	output logic done_frame,
	output logic frame_complete
);

	logic [`LSP_COUNT-1:0] lane_start;
	logic [`LSP_COUNT-1:0] lane_done;
	logic [`LSP_COUNT-1:0] reported;
	lsp_index_t lane_index [`LSP_COUNT];
	lsp_index_t held_index [`LSP_COUNT];
	frame_bits_t frame_word;
	logic all_held;

	for (genvar g = 0; g < `LSP_COUNT; g++)
	begin : g_tap
		assign lane_start[g] = lanes[g].start;
		assign lane_done[g] = lanes[g].done;
		assign lane_index[g] = lanes[g].index;
	end

	assign all_held = &reported;

	// ------------------------------------------------------------
	// index capture
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < `LSP_COUNT; l++)
		begin
			if (lane_done[l])
				held_index[l] <= lane_index[l];
		end
	end

	// ------------------------------------------------------------
	// Gray coding and field placement, LSP 0 at the top
	// ------------------------------------------------------------
	always_comb
	begin
		int pos;
		lsp_index_t gray;
		frame_word = '0;
		frame_word[`FRAME_BITS-1] = voiced_first_q;
		frame_word[`FRAME_BITS-2] = voiced_second_q;
		frame_word[`FRAME_BITS-3 -: `WOE_BITS] = woe_index_q ^ (woe_index_q >> 1);
		pos = `FRAME_BITS - 2 - `WOE_BITS;
		for (int l = 0; l < `LSP_COUNT; l++)
		begin
			gray = held_index[l] ^ (held_index[l] >> 1);
			pos = pos - lsp_index_bits[l];
			for (int b = 0; b < lsp_index_bits[l]; b++)
				frame_word[pos + b] = gray[b];
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			reported <= '0;
			frame_complete <= 1'b0;
			done_frame <= 1'b0;
			encoded_bits <= '0;
		end
		else
		begin
			// a lane start opens a new frame
			if (|lane_start || all_held)
				reported <= '0;
			else
				reported <= reported | lane_done;
			frame_complete <= all_held;
			if (all_held)
				encoded_bits <= frame_word;
			if (|lane_start)
				done_frame <= 1'b0;
			else if (frame_complete)
				done_frame <= 1'b1;
		end
	end

endmodule

//--- rtl/lsp_scalar_quantizer.sv
`include "codec2_params.svh"

module lsp_scalar_quantizer import lsp_pkg::*;
#(
	parameter int unsigned lane_num = 0
)
(
	input  logic clk,
	input  logic rst,
	lsp_lane_if.quant lane
);

	localparam int unsigned entries = lsp_cb_size[lane_num];

	logic busy;
	logic last;
	logic better;
	lsp_index_t ptr;
	lsp_index_t best_idx;
	lsp_t best_diff;
	lsp_t first_diff;
	lsp_t cur_diff;

	function automatic lsp_t abs_diff(lsp_t a, lsp_t b);
		return (a >= b) ? lsp_t'(a - b) : lsp_t'(b - a);
	endfunction

	// entry 0 is scored in the start cycle itself
	assign first_diff = abs_diff(lane.value, lsp_codebook[lane_num][0]);
	assign cur_diff = abs_diff(lane.value, lsp_codebook[lane_num][ptr]);
	// strict compare, so ties stay with the lower index
	assign better = cur_diff < best_diff;
	assign last = busy && (ptr == lsp_index_t'(entries - 1));

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			ptr <= '0;
			lane.done <= 1'b0;
		end
		else
		begin
			lane.done <= last;
			if (lane.start)
			begin
				busy <= 1'b1;
				ptr <= lsp_index_t'(1);
			end
			else if (last)
			begin
				busy <= 1'b0;
				ptr <= '0;
			end
			else if (busy)
				ptr <= ptr + 1'b1;
		end
	end

	// running best and result
	always_ff @(posedge clk)
	begin
		if (lane.start)
		begin
			best_idx <= '0;
			best_diff <= first_diff;
		end
		else if (busy && better)
		begin
			best_idx <= ptr;
			best_diff <= cur_diff;
		end
		if (last)
			lane.index <= better ? ptr : best_idx;
	end

endmodule

//--- rtl/lsp_loader.sv
`include "codec2_params.svh"

module lsp_loader import lsp_pkg::*, frame_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  lsp_vec_t lsp_in,
	input  logic voiced_first,
	input  logic voiced_second,
	input  woe_index_t woe_index,
	input  logic frame_complete,
	lsp_lane_if.loader lanes [`LSP_COUNT],
	output logic voiced_first_q,
	output logic voiced_second_q,
	output woe_index_t woe_index_q
);

	enc_state_t state;
	logic accept;
	logic lane_start;
	lsp_vec_t lsp_q;

	// no new frame while the lanes are searching
	assign accept = start && (state != QUANT);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= IDLE;
			lane_start <= 1'b0;
		end
		else
		begin
			lane_start <= accept;
			if (accept)
				state <= QUANT;
			else if (state == QUANT && frame_complete)
				state <= DONE;
		end
	end

	// frame inputs, held until the next accepted start
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lsp_q <= lsp_in;
			voiced_first_q <= voiced_first;
			voiced_second_q <= voiced_second;
			woe_index_q <= woe_index;
		end
	end

	for (genvar g = 0; g < `LSP_COUNT; g++)
	begin : g_launch
		assign lanes[g].start = lane_start;
		assign lanes[g].value = lsp_q[g];
	end

endmodule

//--- rtl/lsp_lane_if.sv
interface lsp_lane_if import lsp_pkg::*; ();

	logic start;
	lsp_t value;
	lsp_index_t index;
	logic done;

	// sequencer side
	modport loader (output start, output value);

	// quantizer lane
	modport quant (input start, input value, output index, output done);

	// collector, start only marks a new frame
	modport packer (input start, input index, input done);

endinterface

//--- rtl/frame_pkg.sv
`include "codec2_params.svh"

package frame_pkg;

	// frame sequencer states
	typedef enum logic [1:0]
	{
		IDLE,
		QUANT,
		DONE
	} enc_state_t;

	typedef logic [`FRAME_BITS-1:0] frame_bits_t;

	// binary Wo/E quantizer index
	typedef logic [`WOE_BITS-1:0] woe_index_t;

endpackage

//--- rtl/lsp_pkg.sv
`include "codec2_params.svh"

package lsp_pkg;

	typedef logic [`LSP_WIDTH-1:0] lsp_t;
	typedef lsp_t [`LSP_COUNT-1:0] lsp_vec_t;
	typedef logic [$clog2(`CB_MAX)-1:0] lsp_index_t;

	// ------------------------------------------------------------
	// scalar codebooks, one row per LSP, ascending
	// short rows are padded to full length
	// ------------------------------------------------------------
	localparam lsp_t lsp_codebook [`LSP_COUNT][`CB_MAX] = '{
		'{16'd800, 16'd1000, 16'd1200, 16'd1400, 16'd1600, 16'd1800, 16'd2000, 16'd2200,
			16'd2400, 16'd2600, 16'd2800, 16'd3000, 16'd3200, 16'd3400, 16'd3600, 16'd3800},
		'{16'd1600, 16'd1900, 16'd2200, 16'd2500, 16'd2800, 16'd3100, 16'd3400, 16'd3700,
			16'd4000, 16'd4300, 16'd4600, 16'd4900, 16'd5200, 16'd5500, 16'd5800, 16'd6100},
		'{16'd3000, 16'd3400, 16'd3800, 16'd4200, 16'd4600, 16'd5000, 16'd5400, 16'd5800,
			16'd6200, 16'd6600, 16'd7000, 16'd7400, 16'd7800, 16'd8200, 16'd8600, 16'd9000},
		'{16'd4000, 16'd4500, 16'd5000, 16'd5500, 16'd6000, 16'd6500, 16'd7000, 16'd7500,
			16'd8000, 16'd8500, 16'd9000, 16'd9500, 16'd10000, 16'd10500, 16'd11000,
			16'd11500},
		'{16'd6000, 16'd6600, 16'd7200, 16'd7800, 16'd8400, 16'd9000, 16'd9600, 16'd10200,
			16'd10800, 16'd11400, 16'd12000, 16'd12600, 16'd13200, 16'd13800, 16'd14400,
			16'd15000},
		'{16'd8000, 16'd8700, 16'd9400, 16'd10100, 16'd10800, 16'd11500, 16'd12200,
			16'd12900, 16'd13600, 16'd14300, 16'd15000, 16'd15700, 16'd16400, 16'd17100,
			16'd17800, 16'd18500},
		'{16'd10000, 16'd10800, 16'd11600, 16'd12400, 16'd13200, 16'd14000, 16'd14800,
			16'd15600, 16'd16400, 16'd17200, 16'd18000, 16'd18800, 16'd19600, 16'd20400,
			16'd21200, 16'd22000},
		'{16'd14000, 16'd15200, 16'd16400, 16'd17600, 16'd18800, 16'd20000, 16'd21200,
			16'd22400, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff,
			16'hffff, 16'hffff},
		'{16'd18000, 16'd19500, 16'd21000, 16'd22500, 16'd24000, 16'd25500, 16'd27000,
			16'd28500, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff,
			16'hffff, 16'hffff},
		'{16'd24000, 16'd28000, 16'd32000, 16'd36000, 16'hffff, 16'hffff, 16'hffff,
			16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff,
			16'hffff, 16'hffff}
	};

	// live entries per lane
	localparam int unsigned lsp_cb_size [`LSP_COUNT] = '{16, 16, 16, 16, 16, 16, 16, 8, 8, 4};

	// field width of each lane in the frame word
	localparam int unsigned lsp_index_bits [`LSP_COUNT] = '{4, 4, 4, 4, 4, 4, 4, 3, 3, 2};

endpackage

//--- rtl/codec2_params.svh
`ifndef CODEC2_PARAMS_SVH
`define CODEC2_PARAMS_SVH

// LSPs per frame and sample width
`define LSP_COUNT 10
`define LSP_WIDTH 16

// encoded frame layout
`define FRAME_BITS 48
`define WOE_BITS 8

// largest scalar codebook, sets the index width
`define CB_MAX 16

`endif
